// ==== sim/stimSeLoad.txt ====
// 16-bit words. @000: flash bytes, one page of 16 bytes per line, block 0 page 0, page 1, block 1..
// @080 + 20h per test: chEnable, slow flag, then 16 expected mixed samples in output order
@000
00 10 01 10 02 10 03 10 04 10 05 10 06 10 07 10
08 10 09 10 0A 10 0B 10 0C 10 0D 10 0E 10 0F 10
00 F0 01 F0 02 F0 03 F0 04 F0 05 F0 06 F0 07 F0
08 F0 09 F0 0A F0 0B F0 0C F0 0D F0 0E F0 0F F0
00 70 01 70 02 70 03 70 04 70 05 70 06 70 07 70
08 90 09 90 0A 90 0B 90 0C 90 0D 90 0E 90 0F 90
00 20 01 20 02 20 03 20 04 20 05 20 06 20 07 20
08 A0 09 A0 0A A0 0B A0 0C A0 0D A0 0E A0 0F A0
// Test 0: channel 0 alone
@080
0001 0000
1000 1001 1002 1003 1004 1005 1006 1007
1008 1009 100A 100B 100C 100D 100E 100F
// Test 1: channels 0 and 2, positive clamp then plain sums
@0A0
0005 0000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
A010 A012 A014 A016 A018 A01A A01C A01E
// Test 2: all channels, clamps in both directions
@0C0
000F 0000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
8000 8000 8000 8000 8000 8000 8000 8000
// Test 3: channels 1 and 3 with slow ack and flash gaps
@0E0
000A 0001
1000 1002 1004 1006 1008 100A 100C 100E
9010 9012 9014 9016 9018 901A 901C 901E

// ==== build.f ====
verilog/soundPkg.sv
verilog/syncFifo.sv
verilog/flashPageFetch.sv
verilog/channelPacker.sv
verilog/sampleMixer.sv
verilog/seLoadTop.sv
sim/seLoadTop_checker.sv
sim/seLoadTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Compile and run the sound-effect loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
objDir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module seLoadTb \
    -Mdir "$objDir" -o seLoadSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./$objDir/seLoadSim" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation failed" "$logFile"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$logFile"; then
    echo "No result line found in $logFile"
    exit 1
fi
exit 0

// ==== sim/seLoadTb.sv ====
// Needs sim/stimSeLoad.txt run from the project root; only pages 0 and 1 of blocks 0..3 are stored
`timescale 1ns/1ns

module seLoadTb;

    import soundPkg::*;

    localparam int numTests       = 4;
    localparam int samplesPerTest = 16;            // Two pages per enabled channel
    localparam int storedPages    = 2;             // Pages per block held in the stim image
    localparam int testBase       = 'h80;          // First test record
    localparam int testStride     = 'h20;
    localparam int resetCycles    = 16;
    localparam int sampleTimeout  = 4000;          // Cycles allowed per test

    logic                       iSysClk;
    logic                       rstN;
    chMaskT                     chEnable;
    logic                       flashReq;
    logic [flashAddrWidth-1:0]  flashAddr;
    byteT                       flashData;
    logic                       flashDataValid;
    logic                       flashAck;
    logic                       sgbReq;
    sampleT                     sgbSample;
    logic                       sgbAck;

    logic [15:0]            stim [0:255];          // Whole stim image
    sampleT                 expected [samplesPerTest];
    string                  testName [numTests];
    string                  curTest;
    logic                   slowMode;              // Long ack delays, more flash gaps
    int                     recvCount;
    int                     valueErrors;
    int                     otherErrors;
    int                     expPage [chCount];     // Next page expected per channel
    chMaskT                 reqSeen;               // Channels that got a request
    int                     flashState;            // 0 idle, 1 sending, 2 ack high
    int                     byteIdx;
    logic [blockWidth-1:0]  reqBlock;
    pageIdxT                reqPage;
    int                     sgbState;              // 0 idle, 1 delay, 2 ack high
    int                     ackDelay;

    seLoadTop i_seLoadTop (
        .iSysClk        (iSysClk),
        .rstN           (rstN),
        .chEnable       (chEnable),
        .flashReq       (flashReq),
        .flashAddr      (flashAddr),
        .flashData      (flashData),
        .flashDataValid (flashDataValid),
        .flashAck       (flashAck),
        .sgbReq         (sgbReq),
        .sgbSample      (sgbSample),
        .sgbAck         (sgbAck)
    );

    always #2 iSysClk = ~iSysClk;                  // 4 ns period

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic checkAddr(input string name, input logic [flashAddrWidth-1:0] exp,
                             input logic [flashAddrWidth-1:0] act);
        if (act !== exp)
        begin
            valueErrors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkSample(input string name, input sampleT exp, input sampleT act);
        if (act !== exp)
        begin
            valueErrors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkMask(input string name, input chMaskT exp, input chMaskT act);
        if (act !== exp)
        begin
            valueErrors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkReqsLow(input string when);
        if (flashReq !== 1'b0 || sgbReq !== 1'b0)
        begin
            otherErrors++;
            $display("A request was high %s in test %s", when, curTest);
        end
    endtask

    // ----------------------------------------
    // Flash model
    // ----------------------------------------
    // Stored page bytes, else a fill made from block, page and column
    function automatic byteT flashByte(input int blk, input int pg, input int col);
        if (blk < chCount && pg < storedPages)
            return byteT'(stim[blk * storedPages * pageBytes + pg * pageBytes + col]);
        return byteT'(blk * 29 + pg * 7 + col * 3 + 'h5a);
    endfunction

    // Checks one request against the enables and the page order
    task automatic noteRequest();
        int                         ch;
        logic [flashAddrWidth-1:0]  expAddr;
        reqBlock = flashAddr[flashAddrWidth-1 -: blockWidth];
        reqPage  = flashAddr[columnWidth +: pageWidth];
        ch       = int'(reqBlock) % chCount;        // Wrong blocks show up in checkAddr
        checkMask($sformatf("%s request enabled", curTest), chMaskT'(1) << ch,
                  chEnable & (chMaskT'(1) << ch));
        expAddr  = {blockWidth'(ch), pageIdxT'(expPage[ch]), columnWidth'(0)};
        checkAddr($sformatf("%s request address", curTest), expAddr, flashAddr);
        expPage[ch] = (expPage[ch] + 1) % pagesPerBlock;
        reqSeen     = reqSeen | (chMaskT'(1) << ch);
    endtask

    always @(posedge iSysClk)
    begin
        #1;
        if (!rstN)
        begin
            flashState     = 0;
            flashDataValid = 1'b0;
            flashAck       = 1'b0;
        end
        else
        begin
            case (flashState)
                0:
                begin
                    if (flashReq)
                    begin
                        noteRequest();
                        byteIdx    = 0;
                        flashState = 1;
                    end
                end
                1:
                begin
                    if (byteIdx == pageBytes)   // Page sent, raise ack
                    begin
                        flashDataValid = 1'b0;
                        flashAck       = 1'b1;
                        flashState     = 2;
                    end
                    else if (($urandom % (slowMode ? 3 : 8)) == 0)
                    begin
                        flashDataValid = 1'b0;  // Random gap
                    end
                    else
                    begin
                        flashDataValid = 1'b1;
                        flashData      = flashByte(int'(reqBlock), int'(reqPage), byteIdx);
                        byteIdx++;
                    end
                end
                default:
                begin
                    if (!flashReq)
                    begin
                        flashAck   = 1'b0;
                        flashState = 0;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // Sound-generator model
    // ----------------------------------------
    always @(posedge iSysClk)
    begin
        #1;
        if (!rstN)
        begin
            sgbState = 0;
            sgbAck   = 1'b0;
        end
        else
        begin
            case (sgbState)
                0:
                begin
                    if (sgbReq && recvCount < samplesPerTest)   // Stalls once all arrived
                    begin
                        checkSample($sformatf("%s sample %0d", curTest, recvCount),
                                    expected[recvCount], sgbSample);
                        recvCount++;
                        ackDelay = slowMode ? 4 + int'($urandom % 13) : int'($urandom % 2);
                        sgbState = 1;
                    end
                end
                1:
                begin
                    if (ackDelay == 0)
                    begin
                        sgbAck   = 1'b1;
                        sgbState = 2;
                    end
                    else
                    begin
                        ackDelay--;
                    end
                end
                default:
                begin
                    if (!sgbReq)
                    begin
                        sgbAck   = 1'b0;
                        sgbState = 0;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    task automatic runTest(input int t);
        int base;
        int waitCycles;
        base = testBase + t * testStride;
        @(posedge iSysClk);
        #1;
        rstN = 1'b0;
        for (int i = 0; i < resetCycles; i++)
        begin
            @(posedge iSysClk);
            #1;
            if (i == 0)                                 // Load the test inside reset
            begin
                curTest   = testName[t];
                chEnable  = chMaskT'(stim[base]);
                slowMode  = stim[base + 1][0];
                recvCount = 0;
                reqSeen   = '0;
                for (int c = 0; c < chCount; c++)
                    expPage[c] = 0;
                for (int s = 0; s < samplesPerTest; s++)
                    expected[s] = sampleT'(stim[base + 2 + s]);
            end
            checkReqsLow("during reset");
        end
        rstN = 1'b1;
        @(negedge iSysClk);
        checkReqsLow("right after reset");
        waitCycles = 0;
        while (recvCount < samplesPerTest && waitCycles < sampleTimeout)
        begin
            @(posedge iSysClk);
            #1;
            waitCycles++;
        end
        if (recvCount < samplesPerTest)
        begin
            otherErrors++;
            $display("Timeout in test %s: only %0d of %0d samples arrived",
                     curTest, recvCount, samplesPerTest);
        end
        checkMask($sformatf("%s channels requested", curTest), chEnable, reqSeen);
    endtask

    initial
    begin
        void'($urandom(32'hf4d5));
        iSysClk        = 1'b0;
        rstN           = 1'b0;
        chEnable       = '0;
        flashData      = '0;
        flashDataValid = 1'b0;
        flashAck       = 1'b0;
        sgbAck         = 1'b0;
        slowMode       = 1'b0;
        recvCount      = 0;
        valueErrors    = 0;
        otherErrors    = 0;
        reqSeen        = '0;
        curTest        = "startup";
        flashState     = 0;
        sgbState       = 0;
        byteIdx        = 0;
        ackDelay       = 0;
        testName[0]    = "singleChannel";
        testName[1]    = "twoChannels";
        testName[2]    = "fourChannels";
        testName[3]    = "backPressure";
        $readmemh("sim/stimSeLoad.txt", stim);
        for (int t = 0; t < numTests; t++)
            runTest(t);
        $display("Error counts: %0d value mismatches, %0d other failures, %0d assertion failures",
                 valueErrors, otherErrors, i_seLoadTop.i_seLoadTopChecker.assertFails);
        if (valueErrors + otherErrors + i_seLoadTop.i_seLoadTopChecker.assertFails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim/seLoadTop_checker.sv ====
// Handshake rules of the flash and generator sides only; nothing is checked while rstN is low
`timescale 1ns/1ns

module seLoadTop_checker (
    input  logic                                iSysClk,
    input  logic                                rstN,
    input  logic                                flashReq,
    input  logic [soundPkg::flashAddrWidth-1:0] flashAddr,
    input  logic                                flashAck,
    input  logic                                sgbReq,
    input  soundPkg::sampleT                    sgbSample,
    input  logic                                sgbAck
);

    import soundPkg::*;

    int assertFails = 0;                           // Failed assertion tally

    // ----------------------------------------
    // Flash side
    // ----------------------------------------
    flashReqHold: assert property (@(posedge iSysClk) disable iff (!rstN)
        flashReq && !flashAck |=> flashReq)
    else
    begin
        $error("flashReq fell before flashAck");
        assertFails++;
    end

    flashAddrStable: assert property (@(posedge iSysClk) disable iff (!rstN)
        flashReq |=> (!flashReq || $stable(flashAddr)))
    else
    begin
        $error("flashAddr changed while flashReq was high");
        assertFails++;
    end

    flashReqAfterAck: assert property (@(posedge iSysClk) disable iff (!rstN)
        $rose(flashReq) |-> !flashAck)
    else
    begin
        $error("flashReq rose while flashAck was still high");
        assertFails++;
    end

    // ----------------------------------------
    // Sound-generator side
    // ----------------------------------------
    sgbSampleStable: assert property (@(posedge iSysClk) disable iff (!rstN)
        sgbReq |=> (!sgbReq || $stable(sgbSample)))
    else
    begin
        $error("sgbSample changed while sgbReq was high");
        assertFails++;
    end

    sgbReqAfterAck: assert property (@(posedge iSysClk) disable iff (!rstN)
        $rose(sgbReq) |-> !sgbAck)
    else
    begin
        $error("sgbReq rose while sgbAck was still high");
        assertFails++;
    end

endmodule

bind seLoadTop seLoadTop_checker i_seLoadTopChecker (
    .iSysClk   (iSysClk),
    .rstN      (rstN),
    .flashReq  (flashReq),
    .flashAddr (flashAddr),
    .flashAck  (flashAck),
    .sgbReq    (sgbReq),
    .sgbSample (sgbSample),
    .sgbAck    (sgbAck)
);

// ==== verilog/seLoadTop.sv ====
// Only flash and generator sides use four-phase handshakes; chEnable changes only in reset
`timescale 1ns/1ns

module seLoadTop (
    input  logic                                iSysClk,
    input  logic                                rstN,
    input  soundPkg::chMaskT                    chEnable,
    output logic                                flashReq,
    output logic [soundPkg::flashAddrWidth-1:0] flashAddr,
    input  soundPkg::byteT                      flashData,
    input  logic                                flashDataValid,
    input  logic                                flashAck,
    output logic                                sgbReq,
    output soundPkg::sampleT                    sgbSample,
    input  logic                                sgbAck
);

    import soundPkg::*;

    byteT    byteData;                             // Shared byte bus to the packers
    chMaskT  byteWrite;                            // One-hot write select
    chMaskT  pageRoom;
    chMaskT  packValid;
    chMaskT  packTake;
    sampleT  packSample [chCount];

    // ----------------------------------------
    // Flash side
    // ----------------------------------------
    flashPageFetch i_flashPageFetch (
        .iSysClk        (iSysClk),
        .rstN           (rstN),
        .chEnable       (chEnable),
        .pageRoom       (pageRoom),
        .flashData      (flashData),
        .flashDataValid (flashDataValid),
        .flashAck       (flashAck),
        .flashReq       (flashReq),
        .flashAddr      (flashAddr),
        .byteData       (byteData),
        .byteWrite      (byteWrite)
    );

    // ----------------------------------------
    // Per-channel packers
    // ----------------------------------------
    for (genvar g = 0; g < chCount; g++)
    begin : g_packer
        channelPacker i_channelPacker (
            .iSysClk     (iSysClk),
            .rstN        (rstN),
            .byteData    (byteData),
            .byteWrite   (byteWrite[g]),
            .take        (packTake[g]),
            .sampleOut   (packSample[g]),
            .sampleValid (packValid[g]),
            .pageRoom    (pageRoom[g])
        );
    end

    // ----------------------------------------
    // Mixer and generator side
    // ----------------------------------------
    sampleMixer i_sampleMixer (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .chEnable    (chEnable),
        .sampleIn    (packSample),
        .sampleValid (packValid),
        .sgbAck      (sgbAck),
        .take        (packTake),
        .sgbReq      (sgbReq),
        .sgbSample   (sgbSample)
    );

endmodule

// ==== verilog/sampleMixer.sv ====
// chEnable must stay constant outside reset; with no channel enabled nothing is mixed
`timescale 1ns/1ns

module sampleMixer (
    input  logic              iSysClk,
    input  logic              rstN,
    input  soundPkg::chMaskT  chEnable,
    input  soundPkg::sampleT  sampleIn [soundPkg::chCount],
    input  soundPkg::chMaskT  sampleValid,
    input  logic              sgbAck,
    output soundPkg::chMaskT  take,
    output logic              sgbReq,
    output soundPkg::sampleT  sgbSample
);

    import soundPkg::*;

    typedef enum logic [1:0]
    {
        sIdle,
        sReq,
        sWaitAckLow
    } sendStateT;

    logic signed [$bits(sampleT)+$clog2(chCount)-1:0] mixAcc;   // Headroom for the sum
    sampleT      mixClamped;
    sampleT      mixSum;                           // Registered result
    logic        fire;
    logic        pushPending;                      // Push and take next cycle
    sampleT      queueData;
    logic        queueFull;
    logic        queueEmpty;
    logic        queueRd;
    sendStateT   state;

    // ----------------------------------------
    // Mix and clamp
    // ----------------------------------------
    always_comb
    begin
        mixAcc = '0;
        for (int i = 0; i < chCount; i++)
        begin
            if (chEnable[i])
            begin
                mixAcc = mixAcc + sampleIn[i];     // Sign-extended add
            end
        end
        if (mixAcc > sampleMax)
            mixClamped = sampleMax;
        else if (mixAcc < sampleMin)
            mixClamped = sampleMin;
        else
            mixClamped = sampleT'(mixAcc);
    end

    // All enabled channels ready, queue has space
    assign fire = (|chEnable) && (&(sampleValid | ~chEnable)) && !queueFull && !pushPending;

    always_ff @(posedge iSysClk)
    begin
        if (fire)
        begin
            mixSum <= mixClamped;
        end
    end

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            pushPending <= 1'b0;
            take        <= '0;
        end
        else
        begin
            pushPending <= fire;
            take        <= fire ? chEnable : '0;  // Lines up with the push
        end
    end

    // ----------------------------------------
    // Output queue
    // ----------------------------------------
    syncFifo #(
        .payloadT (sampleT),
        .depth    (mixQueueDepth)
    ) i_mixQueue (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .wrData   (mixSum),
        .wrEn     (pushPending),
        .rdEn     (queueRd),
        .rdData   (queueData),
        .full     (queueFull),
        .empty    (queueEmpty),
        .count    ()
    );

    // ----------------------------------------
    // Sound-generator sender
    // ----------------------------------------
    assign queueRd = (state == sIdle) && !queueEmpty;

    always_ff @(posedge iSysClk)
    begin
        if (queueRd)
        begin
            sgbSample <= queueData;                // Held until the next pop
        end
    end

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state  <= sIdle;
            sgbReq <= 1'b0;
        end
        else
        begin
            case (state)
                sIdle:
                begin
                    if (!queueEmpty)
                    begin
                        sgbReq <= 1'b1;
                        state  <= sReq;
                    end
                end

                sReq:
                begin
                    if (sgbAck)
                    begin
                        sgbReq <= 1'b0;
                        state  <= sWaitAckLow;
                    end
                end

                sWaitAckLow:
                begin
                    if (!sgbAck)
                    begin
                        state <= sIdle;            // Generator released ack
                    end
                end

                default:
                begin
                    state <= sIdle;
                end
            endcase
        end
    end

endmodule

// ==== verilog/channelPacker.sv ====
// Bytes arrive low then high; take must only pulse while sampleValid is high
`timescale 1ns/1ns

module channelPacker (
    input  logic              iSysClk,
    input  logic              rstN,
    input  soundPkg::byteT    byteData,
    input  logic              byteWrite,
    input  logic              take,
    output soundPkg::sampleT  sampleOut,
    output logic              sampleValid,
    output logic              pageRoom
);

    import soundPkg::*;

    byteT                               fifoData;  // Oldest byte in the FIFO
    logic                               fifoFull;
    logic                               fifoEmpty;
    logic [$clog2(packerDepth+1)-1:0]   fifoCount;
    logic                               fifoRd;
    byteT                               lowByte;   // Low half of the pending pair
    logic                               lowHeld;

    // ----------------------------------------
    // Byte buffer
    // ----------------------------------------
    syncFifo #(
        .payloadT (byteT),
        .depth    (packerDepth)
    ) i_byteFifo (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .wrData   (byteData),
        .wrEn     (byteWrite && !fifoFull),        // Fetcher honours pageRoom
        .rdEn     (fifoRd),
        .rdData   (fifoData),
        .full     (fifoFull),
        .empty    (fifoEmpty),
        .count    (fifoCount)
    );

    // Room for a whole page in the FIFO
    assign pageRoom = (packerDepth - int'(fifoCount)) >= pageBytes;

    // ----------------------------------------
    // Pair assembly
    // ----------------------------------------
    assign sampleValid = lowHeld && !fifoEmpty;    // Two bytes buffered
    assign sampleOut   = {fifoData, lowByte};      // Low byte first in flash

    // Pop a low byte into the holder, or the high byte on take
    assign fifoRd = (!lowHeld && !fifoEmpty) || (take && sampleValid);

    always_ff @(posedge iSysClk)
    begin
        if (!lowHeld && !fifoEmpty)
        begin
            lowByte <= fifoData;
        end
    end

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            lowHeld <= 1'b0;
        end
        else if (take && sampleValid)
        begin
            lowHeld <= 1'b0;                       // Both bytes consumed
        end
        else if (!fifoEmpty)
        begin
            lowHeld <= 1'b1;
        end
    end

endmodule

// ==== verilog/flashPageFetch.sv ====
// Flash must send exactly pageBytes bytes per request before raising ack; column is always 0
`timescale 1ns/1ns

module flashPageFetch (
    input  logic                                iSysClk,
    input  logic                                rstN,
    input  soundPkg::chMaskT                    chEnable,
    input  soundPkg::chMaskT                    pageRoom,
    input  soundPkg::byteT                      flashData,
    input  logic                                flashDataValid,
    input  logic                                flashAck,
    output logic                                flashReq,
    output logic [soundPkg::flashAddrWidth-1:0] flashAddr,
    output soundPkg::byteT                      byteData,
    output soundPkg::chMaskT                    byteWrite
);

    import soundPkg::*;

    typedef enum logic [1:0]
    {
        fIdle,
        fReq,
        fWaitAckLow
    } fetchStateT;

    fetchStateT  state;
    chIdxT       curCh;                            // Channel being served, also last served
    pageIdxT     pageCnt [chCount];                // Next page per channel
    logic        pickFound;
    chIdxT       pickCh;

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    always_comb
    begin
        int idx;
        pickFound = 1'b0;
        pickCh    = curCh;
        for (int k = chCount; k >= 1; k--)         // Closest after curCh wins
        begin
            idx = (int'(curCh) + k) % chCount;
            if (chEnable[idx] && pageRoom[idx])
            begin
                pickFound = 1'b1;
                pickCh    = chIdxT'(idx);
            end
        end
    end

    // Block is the channel, column stays 0
    assign flashAddr = {blockWidth'(curCh), pageCnt[curCh], columnWidth'(0)};

    // ----------------------------------------
    // Request FSM and page counters
    // ----------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state    <= fIdle;
            curCh    <= chIdxT'(chCount - 1);      // First scan starts at channel 0
            flashReq <= 1'b0;
            for (int i = 0; i < chCount; i++)
            begin
                pageCnt[i] <= '0;
            end
        end
        else
        begin
            case (state)
                fIdle:
                begin
                    if (pickFound)
                    begin
                        curCh    <= pickCh;
                        flashReq <= 1'b1;          // Visible the cycle after the pick
                        state    <= fReq;
                    end
                end

                fReq:
                begin
                    if (flashAck)                  // Page complete
                    begin
                        flashReq <= 1'b0;
                        pageCnt[curCh] <= (int'(pageCnt[curCh]) == pagesPerBlock - 1) ?
                                          '0 : pageCnt[curCh] + 1'b1;
                        state    <= fWaitAckLow;
                    end
                end

                fWaitAckLow:
                begin
                    if (!flashAck)
                    begin
                        state <= fIdle;            // Four-phase exchange closed
                    end
                end

                default:
                begin
                    state <= fIdle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Byte steering
    // ----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        byteData <= flashData;                     // Payload, qualified by byteWrite
    end

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            byteWrite <= '0;
        end
        else if ((state == fReq) && flashDataValid)
        begin
            byteWrite <= chMaskT'(1) << curCh;     // One-hot to the served channel
        end
        else
        begin
            byteWrite <= '0;
        end
    end

endmodule

// ==== verilog/syncFifo.sv ====
// Single clock only; depth of 2 or more; writes when full and reads when empty are dropped
`timescale 1ns/1ns

module syncFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = 4
) (
    input  logic                          iSysClk,
    input  logic                          rstN,
    input  payloadT                       wrData,
    input  logic                          wrEn,
    input  logic                          rdEn,
    output payloadT                       rdData,
    output logic                          full,
    output logic                          empty,
    output logic [$clog2(depth+1)-1:0]    count
);

    payloadT                     mem [depth];      // Circular storage
    logic [$clog2(depth)-1:0]    wrPtr;            // Next slot to write
    logic [$clog2(depth)-1:0]    rdPtr;            // Oldest entry
    logic                        doWr;
    logic                        doRd;

    assign full   = (int'(count) == depth);
    assign empty  = (count == '0);
    assign doWr   = wrEn && !full;                 // Overflow guard
    assign doRd   = rdEn && !empty;                // Underflow guard
    assign rdData = mem[rdPtr];                    // First word falls through

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (doWr)
        begin
            mem[wrPtr] <= wrData;
        end
    end

    // ----------------------------------------
    // Pointers and fill level
    // ----------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doWr)
            begin
                wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;   // Wrap at end
            end
            if (doRd)
            begin
                rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            case ({doWr, doRd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                                  // Both or neither
            endcase
        end
    end

endmodule

// ==== verilog/soundPkg.sv ====
// Sizes assume the 16-byte simulation page and 4 channels; chIdxT must grow with chCount
package soundPkg;

    // ----------------------------------------
    // Channel and page geometry
    // ----------------------------------------
    localparam int chCount       = 4;               // Sound channels
    localparam int pageBytes     = 16;              // Bytes per page, simulation size
    localparam int pagesPerBlock = 64;              // Page counter wraps here
    localparam int packerDepth   = 2 * pageBytes;   // Byte FIFO holds two pages
    localparam int mixQueueDepth = 4;               // Mixed samples waiting for the generator

    // ----------------------------------------
    // Flash address layout
    // ----------------------------------------
    localparam int blockWidth     = 10;             // Bits 26..17
    localparam int pageWidth      = 6;              // Bits 16..11
    localparam int columnWidth    = 11;             // Bits 10..0
    localparam int flashAddrWidth = blockWidth + pageWidth + columnWidth;

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    typedef logic [7:0]             byteT;          // One flash byte
    typedef logic signed [15:0]     sampleT;        // Signed PCM sample
    typedef logic [chCount-1:0]     chMaskT;        // One bit per channel
    typedef logic [1:0]             chIdxT;         // Channel number
    typedef logic [pageWidth-1:0]   pageIdxT;       // Page inside a block

    localparam sampleT sampleMax = 16'sh7fff;       // Clamp ceiling
    localparam sampleT sampleMin = -16'sh8000;      // Clamp floor

endpackage
